/* rtl/sd_pkg.sv */
package sd_pkg;

  // **************************************************************************
  // Block geometry and serial timing
  // **************************************************************************
  localparam int block_bytes = 512;
  localparam int block_bits = block_bytes * 8;
  localparam int addr_bits = 32;
  localparam int init_clk_div = 50;  // System clocks per half sck period while initializing
  localparam int fast_clk_div = 2;
  localparam int init_idle_bytes = 10;  // 80 clocks with cs high
  localparam int r1_wait_limit = 8;  // Polls for R1 before the command is sent again

  // **************************************************************************
  // Commands, tokens and responses
  // **************************************************************************
  localparam logic [5:0] cmd_go_idle = 6'd0;
  localparam logic [5:0] cmd_send_if_cond = 6'd8;
  localparam logic [5:0] cmd_crc_on_off = 6'd59;
  localparam logic [5:0] cmd_app_cmd = 6'd55;
  localparam logic [5:0] acmd_sd_send_op_cond = 6'd41;
  localparam logic [5:0] cmd_read_single = 6'd17;
  localparam logic [5:0] cmd_write_single = 6'd24;
  localparam logic [31:0] if_cond_arg = 32'h0000_01AA;  // Voltage range plus echo pattern
  localparam logic [31:0] acmd41_hcs_arg = 32'h4000_0000;  // Host supports high capacity
  localparam logic [7:0] token_start_block = 8'hFE;
  localparam logic [7:0] data_resp_accepted = 8'h05;

  // CRC7 guards command frames, CRC16 guards data blocks
  localparam int crc7_width = 7;
  localparam logic [crc7_width-1:0] crc7_poly = 7'h09;
  localparam int crc16_width = 16;
  localparam logic [crc16_width-1:0] crc16_poly = 16'h1021;

  typedef enum logic [4:0] {
    st_power_up,
    st_cmd0,
    st_cmd8,
    st_cmd59,
    st_cmd55,
    st_acmd41,
    st_idle,
    st_read_cmd,
    st_read_token,
    st_read_data,
    st_read_crc,
    st_write_cmd,
    st_write_data,
    st_write_resp,
    st_write_busy,
    st_ack
  } sd_state_e;

endpackage

/* rtl/sd_crc.sv */
`timescale 1ns/1ps

module sd_crc
  import sd_pkg::*;
#(
  parameter int width = crc16_width,
  parameter logic [width-1:0] poly = crc16_poly
) (
  input  logic             clock,
  input  logic             rst,
  input  logic             crc_clear,
  input  logic             crc_en,
  input  logic [7:0]       crc_byte,
  output logic [width-1:0] crc_value
);

  // Eight serial LFSR steps unrolled, data enters MSB first
  function automatic logic [width-1:0] fold(input logic [width-1:0] crc,
                                            input logic [7:0] data);
    logic [width-1:0] c;
    logic fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[width-1] ^ data[i];
      c = {c[width-2:0], 1'b0};
      if (fb) begin
        c = c ^ poly;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clock) begin
    if (rst || crc_clear) begin
      crc_value <= '0;
    end else if (crc_en) begin
      crc_value <= fold(crc_value, crc_byte);
    end
  end

endmodule

/* rtl/sd_spi_byte.sv */
`timescale 1ns/1ps

module sd_spi_byte
  import sd_pkg::*;
(
  input  logic       clock,
  input  logic       rst,
  input  logic       fast,
  input  logic       byte_start,
  input  logic [7:0] tx_byte,
  output logic       byte_done,
  output logic [7:0] rx_byte,
  output logic       sck,
  output logic       mosi,
  input  logic       miso
);

  logic       busy;
  logic [6:0] div_cnt;
  logic [6:0] half_period;
  logic [3:0] edge_cnt;  // Sixteen sck edges per byte
  logic [7:0] tx_sh;

  assign half_period = fast ? 7'(fast_clk_div) : 7'(init_clk_div);

  // **************************************************************************
  // Mode 0 shifter: sample on the rising edge, launch on the falling edge
  // **************************************************************************
  always_ff @(posedge clock) begin
    byte_done <= 1'b0;
    if (rst) begin
      busy     <= 1'b0;
      sck      <= 1'b0;
      mosi     <= 1'b1;
      div_cnt  <= '0;
      edge_cnt <= '0;
    end else if (!busy) begin
      if (byte_start) begin
        busy     <= 1'b1;
        mosi     <= tx_byte[7];  // First bit set up before the first rising edge
        tx_sh    <= {tx_byte[6:0], 1'b1};
        div_cnt  <= '0;
        edge_cnt <= '0;
      end
    end else if (div_cnt == half_period - 7'd1) begin
      div_cnt  <= '0;
      sck      <= ~sck;
      edge_cnt <= edge_cnt + 4'd1;
      if (!sck) begin
        rx_byte <= {rx_byte[6:0], miso};
      end else begin
        mosi  <= tx_sh[7];  // Ones fill in behind, so mosi idles high
        tx_sh <= {tx_sh[6:0], 1'b1};
        if (edge_cnt == 4'd15) begin
          busy      <= 1'b0;
          byte_done <= 1'b1;
        end
      end
    end else begin
      div_cnt <= div_cnt + 7'd1;
    end
  end

  // The controller must wait for byte_done before it starts the next byte
  a_no_start_while_busy : assert property (
    @(posedge clock) disable iff (rst) byte_start |-> !busy
  );

endmodule

/* rtl/sd_controller.sv */
`timescale 1ns/1ps

module sd_controller
  import sd_pkg::*;
(
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [addr_bits-1:0]   addr,
  input  logic [block_bits-1:0]  dat_w,
  output logic [block_bits-1:0]  dat_r,
  output logic                   ack,
  output logic                   ready,
  output logic                   crc_error,
  output logic                   cs,
  output logic                   fast,
  output logic                   byte_start,
  output logic [7:0]             tx_byte,
  input  logic                   byte_done,
  input  logic [7:0]             rx_byte,
  output logic                   crc7_clear,
  output logic                   crc7_en,
  output logic [7:0]             crc7_byte,
  input  logic [crc7_width-1:0]  crc7_value,
  output logic                   crc16_clear,
  output logic                   crc16_en,
  output logic [7:0]             crc16_byte,
  input  logic [crc16_width-1:0] crc16_value,
  output sd_state_e              state,
  output logic [7:0]             last_r1
);

  logic                  kick;  // Starts the byte stream once after reset
  logic                  hold;  // Set at ack until the master drops stb
  logic                  step;
  logic [9:0]            byte_cnt;
  logic [2:0]            tail_cnt;  // R7 bytes still to come after CMD8
  logic [39:0]           frame;
  logic [7:0]            crc_hi;
  logic [block_bits-1:0] data_sh;

  assign step = byte_done | kick;

  function automatic logic [39:0] frame_for(input sd_state_e s,
                                            input logic [addr_bits-1:0] a);
    logic [5:0]  idx;
    logic [31:0] arg;
    idx = cmd_go_idle;
    arg = '0;
    case (s)
      st_cmd8: begin
        idx = cmd_send_if_cond;
        arg = if_cond_arg;
      end
      st_cmd59: begin
        idx = cmd_crc_on_off;
        arg = 32'd1;
      end
      st_cmd55: idx = cmd_app_cmd;
      st_acmd41: begin
        idx = acmd_sd_send_op_cond;
        arg = acmd41_hcs_arg;
      end
      st_read_cmd: begin
        idx = cmd_read_single;
        arg = a;
      end
      st_write_cmd: begin
        idx = cmd_write_single;
        arg = a;
      end
      default: idx = cmd_go_idle;
    endcase
    return {2'b01, idx, arg};
  endfunction

  // **************************************************************************
  // Main FSM stepping once per finished byte
  // **************************************************************************
  always_ff @(posedge clock) begin : fsm
    logic      launch;  // Restart a command frame with a leading 0xFF
    logic      send;
    logic [7:0] send_byte;
    sd_state_e launch_st;
    launch = 1'b0;
    send = 1'b0;
    send_byte = 8'hFF;
    launch_st = state;
    if (rst) begin
      state       <= st_power_up;
      kick        <= 1'b1;
      hold        <= 1'b0;
      byte_cnt    <= '0;
      tail_cnt    <= '0;
      cs          <= 1'b1;
      fast        <= 1'b0;
      ready       <= 1'b0;
      ack         <= 1'b0;
      crc_error   <= 1'b0;
      last_r1     <= 8'hFF;
      byte_start  <= 1'b0;
      crc7_clear  <= 1'b0;
      crc7_en     <= 1'b0;
      crc16_clear <= 1'b0;
      crc16_en    <= 1'b0;
    end else begin
      kick        <= 1'b0;
      ack         <= 1'b0;
      byte_start  <= 1'b0;
      crc7_clear  <= 1'b0;
      crc7_en     <= 1'b0;
      crc16_clear <= 1'b0;
      crc16_en    <= 1'b0;
      if (!stb) begin
        hold <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (cyc && stb && !hold) begin
            data_sh   <= dat_w;
            launch    = 1'b1;
            launch_st = we ? st_write_cmd : st_read_cmd;
          end
        end
        st_ack: begin
          ack   <= 1'b1;
          hold  <= 1'b1;
          state <= st_idle;
        end
        default: if (step) begin
          case (state)
            st_power_up: begin
              if (byte_cnt == 10'(init_idle_bytes)) begin
                cs        <= 1'b0;
                launch    = 1'b1;
                launch_st = st_cmd0;
              end else begin
                send = 1'b1;
                byte_cnt <= byte_cnt + 10'd1;
              end
            end
            st_cmd0, st_cmd8, st_cmd59, st_cmd55, st_acmd41, st_read_cmd, st_write_cmd: begin
              if (tail_cnt != 3'd0) begin
                tail_cnt <= tail_cnt - 3'd1;
                if (tail_cnt != 3'd1) begin
                  send = 1'b1;
                end else begin
                  launch = 1'b1;  // Echo mismatch repeats CMD8
                  if (rx_byte == if_cond_arg[7:0]) begin
                    launch_st = st_cmd59;
                  end
                end
              end else if (byte_cnt < 10'd6) begin
                send = 1'b1;
                send_byte = frame[39:32];
                frame     <= {frame[31:0], 8'h00};
                crc7_en   <= 1'b1;
                crc7_byte <= frame[39:32];
                byte_cnt  <= byte_cnt + 10'd1;
              end else if (byte_cnt == 10'd6) begin
                send = 1'b1;
                send_byte = {crc7_value, 1'b1};  // Stop bit closes the frame
                byte_cnt <= byte_cnt + 10'd1;
              end else if (byte_cnt == 10'd7 || rx_byte[7]) begin
                if (byte_cnt == 10'(7 + r1_wait_limit)) begin
                  launch = 1'b1;
                end else begin
                  send = 1'b1;
                  byte_cnt <= byte_cnt + 10'd1;
                end
              end else begin
                last_r1 <= rx_byte;
                case (state)
                  st_cmd0: begin
                    launch = 1'b1;
                    if (rx_byte == 8'h01) begin
                      launch_st = st_cmd8;
                    end
                  end
                  st_cmd8: begin
                    if (rx_byte == 8'h01) begin
                      tail_cnt <= 3'd4;
                      send = 1'b1;
                    end else begin
                      launch = 1'b1;
                    end
                  end
                  st_cmd59: begin
                    launch = 1'b1;
                    if (rx_byte == 8'h01) begin
                      launch_st = st_cmd55;
                    end
                  end
                  st_cmd55: begin
                    launch = 1'b1;
                    if (rx_byte[7:1] == 7'd0) begin
                      launch_st = st_acmd41;
                    end
                  end
                  st_acmd41: begin
                    if (rx_byte == 8'h00) begin
                      state <= st_idle;  // Card left idle
                      fast  <= 1'b1;
                      ready <= 1'b1;
                    end else begin
                      launch = 1'b1;
                      launch_st = st_cmd55;
                    end
                  end
                  st_read_cmd: begin
                    if (rx_byte == 8'h00) begin
                      state <= st_read_token;
                      send = 1'b1;
                    end else begin
                      launch = 1'b1;
                    end
                  end
                  default: begin
                    if (rx_byte == 8'h00) begin
                      state       <= st_write_data;
                      byte_cnt    <= '0;
                      crc16_clear <= 1'b1;
                      send = 1'b1;
                      send_byte = token_start_block;
                    end else begin
                      launch = 1'b1;
                    end
                  end
                endcase
              end
            end
            st_read_token: begin
              send = 1'b1;
              if (rx_byte == token_start_block) begin
                state       <= st_read_data;
                byte_cnt    <= '0;
                crc16_clear <= 1'b1;
              end else if (rx_byte != 8'hFF) begin
                launch = 1'b1;  // An error token asks for the block again
                launch_st = st_read_cmd;
              end
            end
            st_read_data: begin
              send = 1'b1;
              data_sh    <= {data_sh[block_bits-9:0], rx_byte};
              crc16_en   <= 1'b1;
              crc16_byte <= rx_byte;
              byte_cnt   <= byte_cnt + 10'd1;
              if (byte_cnt == 10'(block_bytes - 1)) begin
                state    <= st_read_crc;
                byte_cnt <= '0;
              end
            end
            st_read_crc: begin
              if (byte_cnt == 10'd0) begin
                crc_hi   <= rx_byte;
                byte_cnt <= 10'd1;
                send = 1'b1;
              end else begin
                crc_error <= {crc_hi, rx_byte} != crc16_value;
                dat_r     <= data_sh;
                state     <= st_ack;
              end
            end
            st_write_data: begin
              send = 1'b1;
              byte_cnt <= byte_cnt + 10'd1;
              if (byte_cnt < 10'(block_bytes)) begin
                send_byte = data_sh[block_bits-1 -: 8];
                data_sh    <= {data_sh[block_bits-9:0], 8'h00};
                crc16_en   <= 1'b1;
                crc16_byte <= data_sh[block_bits-1 -: 8];
              end else if (byte_cnt == 10'(block_bytes)) begin
                send_byte = crc16_value[15:8];
              end else if (byte_cnt == 10'(block_bytes + 1)) begin
                send_byte = crc16_value[7:0];
              end else begin
                state <= st_write_resp;
              end
            end
            st_write_resp: begin
              if (rx_byte == 8'hFF) begin
                send = 1'b1;
              end else if ((rx_byte & 8'h1F) == data_resp_accepted) begin
                state <= st_write_busy;
                send = 1'b1;
              end else begin
                state <= st_ack;
              end
            end
            st_write_busy: begin
              if (rx_byte == 8'hFF) begin
                state <= st_ack;  // Card released the data line
              end else begin
                send = 1'b1;
              end
            end
            default: state <= st_idle;
          endcase
        end
      endcase
      if (launch) begin
        state      <= launch_st;
        frame      <= frame_for(launch_st, addr);
        crc7_clear <= 1'b1;
        byte_cnt   <= 10'd1;
        send = 1'b1;
        send_byte = 8'hFF;
      end
      if (send) begin
        byte_start <= 1'b1;
        tx_byte    <= send_byte;
      end
    end
  end

  // ack only answers a request that is still presented and lasts one cycle
  a_ack_single : assert property (
    @(posedge clock) disable iff (rst)
    ack |-> (cyc && stb) ##1 !ack
  );

  // cs only drops right after the last idle byte has finished shifting
  a_cs_after_idle : assert property (
    @(posedge clock) disable iff (rst)
    $fell(cs) |-> $past(byte_done) && $past(byte_cnt) == 10'(init_idle_bytes)
  );

endmodule

/* rtl/sd_controller_top.sv */
`timescale 1ns/1ps

module sd_controller_top
  import sd_pkg::*;
(
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  miso,
  output logic                  cs,
  output logic                  sck,
  output logic                  mosi,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [addr_bits-1:0]  addr,
  input  logic [block_bits-1:0] dat_w,
  output logic [block_bits-1:0] dat_r,
  output logic                  ack,
  output logic                  ready,
  output logic                  crc_error,
  input  logic [1:0]            sw,
  output logic [15:0]           led
);

  logic                   fast;
  logic                   byte_start;
  logic [7:0]             tx_byte;
  logic                   byte_done;
  logic [7:0]             rx_byte;
  logic                   crc7_clear;
  logic                   crc7_en;
  logic [7:0]             crc7_byte;
  logic [crc7_width-1:0]  crc7_value;
  logic                   crc16_clear;
  logic                   crc16_en;
  logic [7:0]             crc16_byte;
  logic [crc16_width-1:0] crc16_value;
  sd_state_e              state;
  logic [7:0]             last_r1;

  sd_controller i_controller (.*);

  sd_spi_byte i_spi_byte (.*);

  sd_crc #(.width(crc7_width), .poly(crc7_poly)) i_crc7 (
    .clock(clock), .rst(rst), .crc_clear(crc7_clear), .crc_en(crc7_en),
    .crc_byte(crc7_byte), .crc_value(crc7_value)
  );

  sd_crc #(.width(crc16_width), .poly(crc16_poly)) i_crc16 (
    .clock(clock), .rst(rst), .crc_clear(crc16_clear), .crc_en(crc16_en),
    .crc_byte(crc16_byte), .crc_value(crc16_value)
  );

  // **************************************************************************
  // LED debug view
  // **************************************************************************
  always_comb begin
    case (sw)
      2'd0: led = {ready, crc_error, 9'd0, state};
      2'd1: led = {8'd0, last_r1};
      2'd2: led = dat_r[15:0];
      default: led = dat_r[block_bits-1 -: 16];  // Top half word of the block
    endcase
  end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter realtime period = 4.0
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever begin
      #(period / 2.0);
      clock = ~clock;
    end
  end

endmodule

/* tb/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model (
  input  logic cs,
  input  logic sck,
  input  logic mosi,
  input  logic corrupt_read,
  output logic miso
);

  logic [7:0]  mem [0:16*512-1];  // Sixteen blocks, addressed by the low address bits
  logic [7:0]  out_q [$];
  logic [7:0]  in_sh;
  logic [7:0]  out_sh;
  logic [47:0] frame;
  logic [47:0] log_frame [0:15];
  logic [5:0]  prev_idx;
  logic [15:0] wr_crc;
  logic        in_idle;
  int          bit_cnt;
  int          frame_cnt;
  int          idle_clocks;
  int          frame_errors;
  int          log_cnt;
  int          acmd41_cnt;
  int          data_cnt;
  int          mode;  // 0 commands, 1 waiting for the write token, 2 write data
  int          blk;

  function automatic logic [6:0] crc7_frame(input logic [39:0] d);
    logic [6:0] c;
    logic fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = c[6] ^ d[i];
      c = {c[5:0], 1'b0};
      if (fb) c = c ^ 7'h09;
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_step(input logic [15:0] c, input logic [7:0] b);
    logic fb;
    for (int i = 7; i >= 0; i--) begin
      fb = c[15] ^ b[i];
      c = {c[14:0], 1'b0};
      if (fb) c = c ^ 16'h1021;
    end
    return c;
  endfunction

  function automatic logic order_ok(input logic [5:0] idx);
    case (idx)
      6'd0: return prev_idx == 6'h3F;
      6'd8: return prev_idx == 6'd0 || prev_idx == 6'd8;
      6'd59: return prev_idx == 6'd8;
      6'd55: return prev_idx == 6'd59 || prev_idx == 6'd41;
      6'd41: return prev_idx == 6'd55;
      6'd17, 6'd24: return !in_idle;
      default: return 1'b0;
    endcase
  endfunction

  initial begin
    for (int i = 0; i < 16 * 512; i++) begin
      mem[i] = 8'(i) ^ 8'(i >> 8);
    end
    out_sh = 8'hFF;
    in_idle = 1'b1;
    prev_idx = 6'h3F;  // No command seen yet
    bit_cnt = 0;
    frame_cnt = 0;
    idle_clocks = 0;
    frame_errors = 0;
    log_cnt = 0;
    acmd41_cnt = 0;
    mode = 0;
  end

  assign miso = cs ? 1'b1 : out_sh[7];

  // ************************************************************************
  // Command decoding and responses
  // ************************************************************************
  task automatic run_command();
    logic [5:0]  idx;
    logic [31:0] arg;
    logic [15:0] c;
    idx = frame[45:40];
    arg = frame[39:8];
    if (frame[7:0] != {crc7_frame(frame[47:8]), 1'b1} || !order_ok(idx)) begin
      frame_errors++;
    end
    if (log_cnt < 16) log_frame[log_cnt] = frame;
    log_cnt++;
    prev_idx = idx;
    case (idx)
      6'd0: begin
        in_idle = 1'b1;
        out_q.push_back(8'h01);
      end
      6'd8: begin
        out_q.push_back(8'h01);
        out_q.push_back(8'h00);
        out_q.push_back(8'h00);
        out_q.push_back({4'h0, arg[11:8]});
        out_q.push_back(arg[7:0]);  // Echo pattern
      end
      6'd59, 6'd55: out_q.push_back({7'd0, in_idle});
      6'd41: begin
        acmd41_cnt++;
        if (acmd41_cnt >= 2) in_idle = 1'b0;  // Ready on the second try
        out_q.push_back({7'd0, in_idle});
      end
      6'd17: begin
        blk = int'(arg[3:0]);
        c = '0;
        out_q.push_back(8'h00);
        out_q.push_back(8'hFE);
        for (int k = 0; k < 512; k++) begin
          out_q.push_back(mem[blk*512+k]);
          c = crc16_step(c, mem[blk*512+k]);
        end
        if (corrupt_read) c = c ^ 16'h0001;
        out_q.push_back(c[15:8]);
        out_q.push_back(c[7:0]);
      end
      6'd24: begin
        blk = int'(arg[3:0]);
        out_q.push_back(8'h00);
        mode = 1;
      end
      default: out_q.push_back(8'h04);  // Illegal command
    endcase
  endtask

  task automatic take_byte(input logic [7:0] b);
    case (mode)
      0: begin
        if (frame_cnt == 0 && b[7:6] == 2'b01) begin
          frame = {40'd0, b};
          frame_cnt = 1;
        end else if (frame_cnt > 0) begin
          frame = {frame[39:0], b};
          frame_cnt++;
          if (frame_cnt == 6) begin
            frame_cnt = 0;
            run_command();
          end
        end
      end
      1: begin
        if (b == 8'hFE) begin
          mode = 2;
          data_cnt = 0;
        end
      end
      default: begin
        if (data_cnt < 512) begin
          mem[blk*512+data_cnt] = b;
        end else if (data_cnt == 512) begin
          wr_crc[15:8] = b;
        end else begin
          wr_crc[7:0] = b;
          mode = 0;
          out_q.push_back(8'hE5);  // Accepted, then a short busy period
          out_q.push_back(8'h00);
          out_q.push_back(8'h00);
          out_q.push_back(8'h00);
        end
        data_cnt++;
      end
    endcase
  endtask

  always @(posedge sck) begin
    if (cs) begin
      if (log_cnt == 0) idle_clocks++;
      bit_cnt = 0;
    end else begin
      in_sh = {in_sh[6:0], mosi};
      bit_cnt++;
      if (bit_cnt == 8) begin
        bit_cnt = 0;
        take_byte(in_sh);
      end
    end
  end

  always @(negedge sck) begin
    if (!cs) begin
      if (bit_cnt == 0) begin
        out_sh = (out_q.size() > 0) ? out_q.pop_front() : 8'hFF;
      end else begin
        out_sh = {out_sh[6:0], 1'b1};
      end
    end
  end

endmodule

/* tb/tb_sd_controller.sv */
`timescale 1ns/1ps

module tb_sd_controller
  import sd_pkg::*;
;

  localparam int init_bytes = 100;  // Generous count for the slow init sequence
  localparam int slow_byte_cycles = 16 * init_clk_div;
  localparam int fast_byte_cycles = 16 * fast_clk_div;
  localparam int timeout_cycles =
    2 * (init_bytes * slow_byte_cycles + 4 * (block_bytes + 32) * fast_byte_cycles);

  logic                  clock;
  logic                  rst;
  logic                  miso;
  logic                  cs;
  logic                  sck;
  logic                  mosi;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [addr_bits-1:0]  addr;
  logic [block_bits-1:0] dat_w;
  logic [block_bits-1:0] dat_r;
  logic                  ack;
  logic                  ready;
  logic                  crc_error;
  logic [1:0]            sw;
  logic [15:0]           led;
  logic                  corrupt_read;

  logic [15:0]           lfsr;
  logic                  exp_read;
  logic                  exp_crc_error;
  logic [block_bits-1:0] exp_data;
  logic [block_bits-1:0] blk_a;
  logic [block_bits-1:0] blk_b;
  int                    error_count;
  int                    ack_count;

  tb_clock_gen #(.period(4.0)) i_clock_gen (.clock(clock));

  sd_controller_top i_sd_controller_top (.*);

  sd_card_model i_card (
    .cs(cs), .sck(sck), .mosi(mosi), .corrupt_read(corrupt_read), .miso(miso)
  );

  // **************************************************************************
  // Reference models
  // **************************************************************************
  function automatic logic [6:0] crc7_ref(input logic [39:0] d);
    logic [6:0] c;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      c = (c[6] ^ d[i]) ? ({c[5:0], 1'b0} ^ 7'h09) : {c[5:0], 1'b0};
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_ref(input logic [block_bits-1:0] d);
    logic [15:0] c;
    c = '0;
    for (int i = block_bits - 1; i >= 0; i--) begin
      c = (c[15] ^ d[i]) ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
    end
    return c;
  endfunction

  function automatic logic [15:0] led_ref(input logic [1:0] s, input logic rdy,
                                          input logic err, input logic [7:0] r1,
                                          input logic [block_bits-1:0] d);
    case (s)
      2'd0: return {rdy, err, 9'd0, 5'(st_idle)};
      2'd1: return {8'd0, r1};
      2'd2: return d[15:0];
      default: return d[block_bits-1 -: 16];
    endcase
  endfunction

  // Block content as the card model fills it
  function automatic logic [block_bits-1:0] known_block(input int b);
    logic [block_bits-1:0] d;
    int a;
    for (int k = 0; k < block_bytes; k++) begin
      a = b * 512 + k;
      d[block_bits-1-8*k -: 8] = 8'(a) ^ 8'(a >> 8);
    end
    return d;
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ({1'b0, s[15:1]} ^ 16'hB400) : {1'b0, s[15:1]};
  endfunction

  function automatic int first_diff(input logic [block_bits-1:0] a,
                                    input logic [block_bits-1:0] b);
    for (int k = 0; k < block_bytes; k++) begin
      if (a[block_bits-1-8*k -: 8] !== b[block_bits-1-8*k -: 8]) return k;
    end
    return -1;
  endfunction

  task automatic random_block(output logic [block_bits-1:0] d);
    for (int i = 0; i < block_bits; i++) begin
      d[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // One bus request that keeps stb high for extra_hold cycles after ack
  task automatic bus_access(input logic write, input logic [31:0] a,
                            input logic [block_bits-1:0] d, input int extra_hold);
    int acks_before;
    acks_before = ack_count;
    @(posedge clock);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    addr  <= a;
    dat_w <= d;
    @(negedge clock);
    while (!ack) @(negedge clock);
    repeat (extra_hold) @(posedge clock);
    @(posedge clock);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    repeat (4) @(negedge clock);
    check_value("ack pulses", ack_count - acks_before, 1);
  endtask

  // **************************************************************************
  // Compare process with one check per ack
  // **************************************************************************
  always @(negedge clock) begin
    if (!rst && ack) begin
      ack_count++;
      if (exp_read) begin
        assert (dat_r === exp_data) else begin
          $display("[ERROR] dat_r byte %0d: got %h expected %h",
                   first_diff(dat_r, exp_data),
                   dat_r[block_bits-1-8*first_diff(dat_r, exp_data) -: 8],
                   exp_data[block_bits-1-8*first_diff(dat_r, exp_data) -: 8]);
          error_count++;
        end
        check_value("crc_error", crc_error, exp_crc_error);
      end
    end
  end

  initial begin
    #(timeout_cycles * 4ns);
    $display("Timeout: the DUT stopped making progress");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    addr = '0;
    dat_w = '0;
    sw = 2'd0;
    corrupt_read = 1'b0;
    lfsr = 16'd62;
    exp_read = 1'b0;
    exp_crc_error = 1'b0;
    exp_data = '0;
    error_count = 0;
    ack_count = 0;

    repeat (16) begin
      @(negedge clock);
      check_value("cs", cs, 1);
      check_value("ack", ack, 0);
      check_value("ready", ready, 0);
      check_value("crc_error", crc_error, 0);
    end
    @(posedge clock);
    rst <= 1'b0;
    @(negedge clock);
    check_value("cs", cs, 1);
    check_value("ready", ready, 0);
    while (!ready) @(negedge clock);
    check_value("ack pulses", ack_count, 0);
    check_value("crc_error", crc_error, 0);

    // Init sequence as seen by the card
    assert (i_card.idle_clocks >= 80) else begin
      $display("Fewer than 80 clocks with cs high before CMD0: %0d", i_card.idle_clocks);
      error_count++;
    end
    check_value("cmd index 0", i_card.log_frame[0][45:40], 0);
    check_value("cmd index 1", i_card.log_frame[1][45:40], 8);
    check_value("cmd index 2", i_card.log_frame[2][45:40], 59);
    check_value("cmd index 3", i_card.log_frame[3][45:40], 55);
    check_value("cmd index 4", i_card.log_frame[4][45:40], 41);
    for (int k = 0; k < i_card.log_cnt && k < 16; k++) begin
      check_value("cmd crc7", i_card.log_frame[k][7:1], crc7_ref(i_card.log_frame[k][47:8]));
    end

    random_block(blk_a);
    bus_access(1'b1, 32'd5, blk_a, 0);
    check_value("card write crc16", i_card.wr_crc, crc16_ref(blk_a));

    exp_read = 1'b1;
    exp_data = blk_a;
    bus_access(1'b0, 32'd5, '0, 0);

    corrupt_read = 1'b1;  // Bad CRC16 on the next read of block 9
    exp_data = known_block(9);
    exp_crc_error = 1'b1;
    bus_access(1'b0, 32'd9, '0, 0);
    corrupt_read = 1'b0;
    exp_crc_error = 1'b0;
    bus_access(1'b0, 32'd9, '0, 0);

    for (int s = 0; s < 4; s++) begin
      @(posedge clock);
      sw <= 2'(s);
      @(negedge clock);
      check_value("led", led, led_ref(2'(s), 1'b1, 1'b0, 8'h00, exp_data));
    end

    // Back to back requests with the first holding stb past ack
    random_block(blk_b);
    exp_read = 1'b0;
    bus_access(1'b1, 32'd3, blk_b, 6);
    exp_read = 1'b1;
    exp_data = blk_b;
    bus_access(1'b0, 32'd3, '0, 0);

    assert (i_card.frame_errors == 0) else begin
      $display("Card model saw bad or out of order command frames");
      error_count++;
    end
    $display("Checks finished: %0d errors, %0d acks, %0d bad command frames",
             error_count, ack_count, i_card.frame_errors);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
rtl/sd_pkg.sv
rtl/sd_crc.sv
rtl/sd_spi_byte.sv
rtl/sd_controller.sv
rtl/sd_controller_top.sv
tb/tb_clock_gen.sv
tb/sd_card_model.sv
tb/tb_sd_controller.sv
